// File: src/fft_types_pkg.sv
//==========================================================
// FFT sample types
// fixed-point widths and the complex sample word shared by
// the datapath, the sample store and the stream ports
//==========================================================
package fft_types_pkg;

  // width of one real or imaginary part
  localparam int sample_w = 16;

  // fraction bits in samples and twiddles (Q1.14)
  localparam int frac_w = 14;

  // complex sample, re in the upper half
  typedef struct packed {
    logic signed [sample_w-1:0] re;
    logic signed [sample_w-1:0] im;
  } cplx_t;

  // one RAM word
  // the store keeps raw bits, the datapath reads re/im
  typedef union packed {
    cplx_t                   part;
    logic [2*sample_w-1:0]   raw;
  } cplx_u;

endpackage

// File: src/fft_ctrl_pkg.sv
//==========================================================
// FFT control definitions
// sequencer state encoding and supported transform sizes
//==========================================================
package fft_ctrl_pkg;

  // smallest and largest supported log2 of the block size
  localparam int min_log2_points = 3;
  localparam int max_log2_points = 4;

  // sequencer states
  // IDLE    one cycle after reset
  // LOAD    accept input samples, bit-reversed writes
  // RUN     issue one butterfly
  // WAIT_BF wait for the result, then write both outputs back
  // UNLOAD  send the spectrum in natural order
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    RUN,
    WAIT_BF,
    UNLOAD
  } fft_state_e;

endpackage

// File: src/fft_complex_mult.sv
//==========================================================
// Iterative complex multiplier
// p = a * w with four real shift-add products formed side by
// side, one multiplier bit per cycle, then one cycle to
// combine and drop the fraction bits (floor rounding)
//==========================================================
`timescale 1ns/100ps

module fft_complex_mult (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 recv_val,
  output logic                 recv_rdy,
  output logic                 send_val,
  input  logic                 send_rdy,
  input  fft_types_pkg::cplx_t a,
  input  fft_types_pkg::cplx_t w,
  output fft_types_pkg::cplx_t p
);
  import fft_types_pkg::*;

  localparam int cnt_w = $clog2(sample_w);

  // iteration control
  logic             busy;
  logic             finish;
  logic [cnt_w-1:0] cnt;
  logic             last_bit;
  logic             accept;

  // multiplicands shift left, multipliers shift right
  logic signed [2*sample_w-1:0] mc_re, mc_im;
  logic        [sample_w-1:0]   mp_re, mp_im;

  // rr = a.re*w.re  ii = a.im*w.im  ri = a.re*w.im  ir = a.im*w.re
  logic signed [2*sample_w-1:0] acc_rr, acc_ii, acc_ri, acc_ir;
  logic signed [2*sample_w:0]   re_full, im_full;

  // one partial product
  // the sign bit of a two's complement multiplier has negative weight
  function automatic logic signed [2*sample_w-1:0] partial(
    input logic signed [2*sample_w-1:0] mc,
    input logic                         bit_v,
    input logic                         msb
  );
    if (!bit_v) begin
      return '0;
    end
    return msb ? -mc : mc;
  endfunction

  assign recv_rdy = !busy && !finish && !send_val;
  assign accept   = recv_val && recv_rdy;
  assign last_bit = (cnt == cnt_w'(sample_w - 1));

  //==========================================================
  // control
  //==========================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy     <= 1'b0;
      finish   <= 1'b0;
      send_val <= 1'b0;
      cnt      <= '0;
    end else begin
      finish <= 1'b0;
      if (accept) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (last_bit) begin
          busy   <= 1'b0;
          finish <= 1'b1;
        end
      end
      // result is held until the consumer takes it
      if (finish) begin
        send_val <= 1'b1;
      end else if (send_val && send_rdy) begin
        send_val <= 1'b0;
      end
    end
  end

  //==========================================================
  // datapath
  //==========================================================
  // widen before the difference and the sum
  assign re_full = (2*sample_w+1)'(acc_rr) - (2*sample_w+1)'(acc_ii);
  assign im_full = (2*sample_w+1)'(acc_ri) + (2*sample_w+1)'(acc_ir);

  always_ff @(posedge clk) begin
    if (accept) begin
      mc_re  <= (2*sample_w)'(a.re);
      mc_im  <= (2*sample_w)'(a.im);
      mp_re  <= w.re;
      mp_im  <= w.im;
      acc_rr <= '0;
      acc_ii <= '0;
      acc_ri <= '0;
      acc_ir <= '0;
    end else if (busy) begin
      mc_re  <= mc_re <<< 1;
      mc_im  <= mc_im <<< 1;
      mp_re  <= mp_re >> 1;
      mp_im  <= mp_im >> 1;
      acc_rr <= acc_rr + partial(mc_re, mp_re[0], last_bit);
      acc_ii <= acc_ii + partial(mc_im, mp_im[0], last_bit);
      acc_ri <= acc_ri + partial(mc_re, mp_im[0], last_bit);
      acc_ir <= acc_ir + partial(mc_im, mp_re[0], last_bit);
    end
    // arithmetic shift rounds toward minus infinity
    if (finish) begin
      p.re <= sample_w'(re_full >>> frac_w);
      p.im <= sample_w'(im_full >>> frac_w);
    end
  end

  // no second operand is taken before the previous result leaves,
  // and that result appears exactly sample_w+1 cycles after accept
  assert property (@(posedge clk) disable iff (!arst_n)
    accept |=> (!recv_rdy throughout (##(sample_w+1) send_val)))
    else $error("multiplier accepted an operand while busy or missed its latency");

endmodule

// File: src/fft_butterfly.sv
//==========================================================
// Iterative radix-2 butterfly
// c = a + w*b, d = a - w*b, sharing one iterative complex
// multiplier; a is captured when the operands are accepted
//==========================================================
`timescale 1ns/100ps

module fft_butterfly (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 recv_val,
  output logic                 recv_rdy,
  output logic                 send_val,
  input  logic                 send_rdy,
  input  fft_types_pkg::cplx_t a,
  input  fft_types_pkg::cplx_t b,
  input  fft_types_pkg::cplx_t w,
  output fft_types_pkg::cplx_t c,
  output fft_types_pkg::cplx_t d
);
  import fft_types_pkg::*;

  // a as seen at accept
  cplx_t a_q;
  // w*b from the multiplier, valid while send_val is high
  cplx_t prod;

  // handshake is owned by the multiplier
  fft_complex_mult mult0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .a        (b),
    .w        (w),
    .p        (prod)
  );

  always_ff @(posedge clk) begin
    if (recv_val && recv_rdy) begin
      a_q <= a;
    end
  end

  // sum and difference wrap at sample_w bits
  assign c.re = a_q.re + prod.re;
  assign c.im = a_q.im + prod.im;
  assign d.re = a_q.re - prod.re;
  assign d.im = a_q.im - prod.im;

endmodule

// File: src/fft_sample_ram.sv
//==========================================================
// Sample store
// register file holding one block in place, two combinational
// reads and two writes per clock
//==========================================================
`timescale 1ns/100ps

module fft_sample_ram #(
  parameter int LOG2_POINTS = 3
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic [LOG2_POINTS-1:0] raddr0,
  input  logic [LOG2_POINTS-1:0] raddr1,
  output fft_types_pkg::cplx_u   rdata0,
  output fft_types_pkg::cplx_u   rdata1,
  input  logic                   we0,
  input  logic                   we1,
  input  logic [LOG2_POINTS-1:0] waddr0,
  input  logic [LOG2_POINTS-1:0] waddr1,
  input  fft_types_pkg::cplx_u   wdata0,
  input  fft_types_pkg::cplx_u   wdata1
);
  import fft_types_pkg::*;

  localparam int points = 1 << LOG2_POINTS;

  // raw words, the union view is chosen at the ports
  logic [2*sample_w-1:0] mem [points];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < points; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (we0) begin
        mem[waddr0] <= wdata0.raw;
      end
      if (we1) begin
        mem[waddr1] <= wdata1.raw;
      end
    end
  end

  assign rdata0.raw = mem[raddr0];
  assign rdata1.raw = mem[raddr1];

  // butterfly write-back always targets two distinct addresses
  assert property (@(posedge clk) disable iff (!arst_n)
    !(we0 && we1 && (waddr0 == waddr1)))
    else $error("both write ports hit address %0d", waddr0);

endmodule

// File: src/fft_twiddle_rom.sv
//==========================================================
// Twiddle table
// cos and -sin of 2*pi*k/16 for k = 0..7 in Q1.14; smaller
// sizes arrive here with an already scaled index
//==========================================================
`timescale 1ns/100ps

module fft_twiddle_rom (
  input  logic [fft_ctrl_pkg::max_log2_points-2:0] idx,
  output fft_types_pkg::cplx_t                     w
);
  import fft_types_pkg::*;

  logic signed [sample_w-1:0] cos_v;
  logic signed [sample_w-1:0] msin_v;

  always_comb begin
    case (idx)
      3'd0:    begin cos_v =  16'sd16384; msin_v =  16'sd0;     end
      3'd1:    begin cos_v =  16'sd15137; msin_v = -16'sd6270;  end
      3'd2:    begin cos_v =  16'sd11585; msin_v = -16'sd11585; end
      3'd3:    begin cos_v =  16'sd6270;  msin_v = -16'sd15137; end
      3'd4:    begin cos_v =  16'sd0;     msin_v = -16'sd16384; end
      3'd5:    begin cos_v = -16'sd6270;  msin_v = -16'sd15137; end
      3'd6:    begin cos_v = -16'sd11585; msin_v = -16'sd11585; end
      default: begin cos_v = -16'sd15137; msin_v = -16'sd6270;  end
    endcase
  end

  assign w.re = cos_v;
  assign w.im = msin_v;

endmodule

// File: src/fft_addr_counter.sv
//==========================================================
// Butterfly address counter
// walks stage, group and pair; gives both butterfly
// addresses and the twiddle index for the current pair
//==========================================================
`timescale 1ns/100ps

module fft_addr_counter #(
  parameter int LOG2_POINTS = 3
) (
  input  logic                                     clk,
  input  logic                                     arst_n,
  input  logic                                     clear,
  input  logic                                     step,
  output logic [LOG2_POINTS-1:0]                   addr_a,
  output logic [LOG2_POINTS-1:0]                   addr_b,
  output logic [fft_ctrl_pkg::max_log2_points-2:0] tw_idx,
  output logic                                     last_pair,
  output logic                                     last_stage
);
  import fft_ctrl_pkg::*;

  localparam int points  = 1 << LOG2_POINTS;
  localparam int stage_w = $clog2(LOG2_POINTS);

  // stage counts from zero, span of a stage is 2^(stage+1)
  logic [stage_w-1:0]     stage;
  logic [LOG2_POINTS-2:0] group;
  logic [LOG2_POINTS-2:0] pair;

  // half span and number of groups in this stage
  logic [LOG2_POINTS-1:0] half;
  logic [LOG2_POINTS-1:0] groups;
  logic                   pair_end;
  logic                   group_end;

  assign half      = LOG2_POINTS'(1) << stage;
  assign groups    = LOG2_POINTS'(points >> (stage + 1));
  assign pair_end  = (LOG2_POINTS'(pair) == half - 1'b1);
  assign group_end = (LOG2_POINTS'(group) == groups - 1'b1);

  // a sits at group*span + pair, b half a span above
  assign addr_a = (LOG2_POINTS'(group) << (stage + 1)) | LOG2_POINTS'(pair);
  assign addr_b = addr_a | half;

  // index into the 16-point table
  // pair scaled by max exponent minus the one-based stage
  assign tw_idx = (max_log2_points - 1)'(pair) << (max_log2_points - 1 - stage);

  assign last_pair  = pair_end && group_end;
  assign last_stage = (stage == stage_w'(LOG2_POINTS - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stage <= '0;
      group <= '0;
      pair  <= '0;
    end else if (clear) begin
      stage <= '0;
      group <= '0;
      pair  <= '0;
    end else if (step) begin
      if (!pair_end) begin
        pair <= pair + 1'b1;
      end else begin
        pair <= '0;
        if (!group_end) begin
          group <= group + 1'b1;
        end else begin
          group <= '0;
          stage <= last_stage ? '0 : stage + 1'b1;
        end
      end
    end
  end

endmodule

// File: src/fft_ctrl_fsm.sv
//==========================================================
// FFT sequencer
// loads a block in bit-reversed order, runs one butterfly
// at a time with write-back, then unloads in natural order
//==========================================================
`timescale 1ns/100ps

module fft_ctrl_fsm #(
  parameter int LOG2_POINTS = 3
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   in_val,
  output logic                   in_rdy,
  output logic                   out_val,
  input  logic                   out_rdy,
  output logic                   bf_val,
  input  logic                   bf_rdy,
  input  logic                   bf_done_val,
  output logic                   bf_done_rdy,
  output logic                   cnt_clear,
  output logic                   cnt_step,
  input  logic                   last_pair,
  input  logic                   last_stage,
  output logic                   load_we,
  output logic [LOG2_POINTS-1:0] io_addr,
  output logic                   bf_we,
  output logic                   use_bf_addr
);
  import fft_ctrl_pkg::*;

  localparam int points = 1 << LOG2_POINTS;

  fft_state_e             state, state_nx;
  // load and unload index, wraps by itself at the block end
  logic [LOG2_POINTS-1:0] idx;
  logic [LOG2_POINTS-1:0] idx_rev;
  logic                   in_fire;
  logic                   out_fire;
  logic                   idx_last;

  always_comb begin
    for (int i = 0; i < LOG2_POINTS; i++) begin
      idx_rev[i] = idx[LOG2_POINTS-1-i];
    end
  end

  assign in_rdy      = (state == LOAD);
  assign out_val     = (state == UNLOAD);
  assign bf_val      = (state == RUN);
  assign bf_done_rdy = (state == WAIT_BF);
  assign use_bf_addr = (state == RUN) || (state == WAIT_BF);

  assign in_fire  = in_val && in_rdy;
  assign out_fire = out_val && out_rdy;
  assign idx_last = (idx == LOG2_POINTS'(points - 1));

  // load writes go to bit-reversed addresses
  assign io_addr = (state == LOAD) ? idx_rev : idx;
  assign load_we = in_fire;

  // write-back cycle also advances the counter
  assign bf_we     = bf_done_val && bf_done_rdy;
  assign cnt_step  = bf_we;
  assign cnt_clear = in_fire && idx_last;

  //==========================================================
  // next state
  //==========================================================
  always_comb begin
    state_nx = state;
    case (state)
      IDLE:    state_nx = LOAD;
      LOAD:    if (in_fire && idx_last) state_nx = RUN;
      RUN:     if (bf_val && bf_rdy) state_nx = WAIT_BF;
      WAIT_BF: if (bf_we) state_nx = (last_pair && last_stage) ? UNLOAD : RUN;
      UNLOAD:  if (out_fire && idx_last) state_nx = LOAD;
      default: state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      idx   <= '0;
    end else begin
      state <= state_nx;
      // out_rdy low keeps the read address
      if (in_fire || out_fire) begin
        idx <= idx + 1'b1;
      end
    end
  end

  // output only starts right after the final write-back
  assert property (@(posedge clk) disable iff (!arst_n)
    $rose(out_val) |-> $past(bf_we && last_pair && last_stage))
    else $error("out_val raised before the transform finished");

endmodule

// File: src/fft_engine.sv
//==========================================================
// Radix-2 DIT FFT engine
// in-place transform of one block with a single iterative
// butterfly, valid/ready streams in and out
//==========================================================
`timescale 1ns/100ps

module fft_engine #(
  parameter int LOG2_POINTS = 3
) (
  input  logic                                    clk,
  input  logic                                    arst_n,
  input  logic                                    in_val,
  output logic                                    in_rdy,
  input  logic signed [fft_types_pkg::sample_w-1:0] in_re,
  input  logic signed [fft_types_pkg::sample_w-1:0] in_im,
  output logic                                    out_val,
  input  logic                                    out_rdy,
  output logic signed [fft_types_pkg::sample_w-1:0] out_re,
  output logic signed [fft_types_pkg::sample_w-1:0] out_im
);
  import fft_types_pkg::*;
  import fft_ctrl_pkg::*;

  if (LOG2_POINTS < min_log2_points || LOG2_POINTS > max_log2_points) begin : g_size_check
    $error("LOG2_POINTS %0d out of range", LOG2_POINTS);
  end

  // sequencer to butterfly and counter
  logic bf_val, bf_rdy, bf_done_val, bf_done_rdy;
  logic cnt_clear, cnt_step, last_pair, last_stage;
  logic load_we, bf_we, use_bf_addr;

  logic [LOG2_POINTS-1:0]         io_addr, addr_a, addr_b;
  logic [LOG2_POINTS-1:0]         port0_addr;
  logic [max_log2_points-2:0]     tw_idx;

  cplx_u rdata0, rdata1, wdata0, wdata1;
  cplx_t in_word, tw, bf_c, bf_d;

  fft_ctrl_fsm #(.LOG2_POINTS(LOG2_POINTS)) fsm0 (
    .clk (clk), .arst_n (arst_n),
    .in_val (in_val), .in_rdy (in_rdy), .out_val (out_val), .out_rdy (out_rdy),
    .bf_val (bf_val), .bf_rdy (bf_rdy),
    .bf_done_val (bf_done_val), .bf_done_rdy (bf_done_rdy),
    .cnt_clear (cnt_clear), .cnt_step (cnt_step),
    .last_pair (last_pair), .last_stage (last_stage),
    .load_we (load_we), .io_addr (io_addr), .bf_we (bf_we), .use_bf_addr (use_bf_addr)
  );

  fft_addr_counter #(.LOG2_POINTS(LOG2_POINTS)) cnt0 (
    .clk (clk), .arst_n (arst_n), .clear (cnt_clear), .step (cnt_step),
    .addr_a (addr_a), .addr_b (addr_b), .tw_idx (tw_idx),
    .last_pair (last_pair), .last_stage (last_stage)
  );

  fft_twiddle_rom rom0 (
    .idx (tw_idx),
    .w   (tw)
  );

  //==========================================================
  // RAM port steering
  //==========================================================
  // port 0 carries load/unload traffic or butterfly a,
  // port 1 is used by the butterfly only
  assign port0_addr  = use_bf_addr ? addr_a : io_addr;
  assign in_word     = '{re: in_re, im: in_im};
  assign wdata0.part = use_bf_addr ? bf_c : in_word;
  assign wdata1.part = bf_d;

  fft_sample_ram #(.LOG2_POINTS(LOG2_POINTS)) ram0 (
    .clk (clk), .arst_n (arst_n),
    .raddr0 (port0_addr), .raddr1 (addr_b),
    .rdata0 (rdata0), .rdata1 (rdata1),
    .we0 (load_we || bf_we), .we1 (bf_we),
    .waddr0 (port0_addr), .waddr1 (addr_b),
    .wdata0 (wdata0), .wdata1 (wdata1)
  );

  fft_butterfly bf0 (
    .clk (clk), .arst_n (arst_n),
    .recv_val (bf_val), .recv_rdy (bf_rdy),
    .send_val (bf_done_val), .send_rdy (bf_done_rdy),
    .a (rdata0.part), .b (rdata1.part), .w (tw),
    .c (bf_c), .d (bf_d)
  );

  // unload reads natural-order words on port 0
  assign out_re = rdata0.part.re;
  assign out_im = rdata0.part.im;

endmodule

// File: tests/fft_tb_cases.svh
//==========================================================
// FFT testbench case table
// eight-point input blocks, one per case, with a flag that
// stalls out_rdy at random during the unload
//==========================================================
`ifndef FFT_TB_CASES_SVH
`define FFT_TB_CASES_SVH

// columns: name | stall out_rdy | re[0..7] | im[0..7]
// magnitudes stay below 1/8 of full scale, no bin can overflow
localparam int num_cases = 7;

string case_name [num_cases] = '{
  "impulse", "constant", "tone_k1", "tone_k3",
  "random", "random_stall", "zero_after"
};

bit case_stall [num_cases] = '{0, 0, 0, 0, 0, 1, 0};

int case_re [num_cases][points] = '{
  '{3000,     0,    0,     0,     0,    0,     0,    0},
  '{2000,  2000, 2000,  2000,  2000, 2000,  2000, 2000},
  '{1000,   707,    0,  -707, -1000, -707,     0,  707},
  '{1000,  -707,    0,   707, -1000,  707,     0, -707},
  '{1234, -2011,  877,  2450, -1503,  312, -2299, 1688},
  '{1234, -2011,  877,  2450, -1503,  312, -2299, 1688},
  '{   0,     0,    0,     0,     0,    0,     0,    0}
};

int case_im [num_cases][points] = '{
  '{   0,     0,    0,     0,     0,     0,     0,     0},
  '{-1000, -1000, -1000, -1000, -1000, -1000, -1000, -1000},
  '{   0,   707, 1000,   707,     0,  -707, -1000,  -707},
  '{   0,   707, -1000,  707,     0,  -707,  1000,  -707},
  '{-905,  1766, 2187,  -431,    95, -2388,  1420, -1127},
  '{-905,  1766, 2187,  -431,    95, -2388,  1420, -1127},
  '{   0,     0,    0,     0,     0,     0,     0,     0}
};

`endif

// File: tests/fft_engine_tb.sv
//==========================================================
// FFT engine testbench
// streams the case table through the engine back to back and
// checks every bin against a real-valued DFT
//==========================================================
`timescale 1ns/100ps

module fft_engine_tb;
  import fft_types_pkg::*;

  localparam int  log2_points    = 3;
  localparam int  points         = 1 << log2_points;
  localparam int  timeout_cycles = 2000;
  localparam real pi             = 3.14159265358979;

  `include "fft_tb_cases.svh"

  logic                       clk;
  logic                       arst_n;
  logic                       in_val;
  logic                       in_rdy;
  logic signed [sample_w-1:0] in_re;
  logic signed [sample_w-1:0] in_im;
  logic                       out_val;
  logic                       out_rdy;
  logic signed [sample_w-1:0] out_re;
  logic signed [sample_w-1:0] out_im;

  integer seed;
  int     case_errs;
  int     errors;
  int     tests_failed;
  bit     timed_out;

  fft_engine #(.LOG2_POINTS(log2_points)) dut0 (
    .clk (clk), .arst_n (arst_n),
    .in_val (in_val), .in_rdy (in_rdy), .in_re (in_re), .in_im (in_im),
    .out_val (out_val), .out_rdy (out_rdy), .out_re (out_re), .out_im (out_im)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // real or imaginary part of bin k of case c
  // X[k] = sum x[n] e^(-j 2 pi k n / N)
  function automatic real dft_part(input int c, input int k, input bit imag);
    real acc;
    real ang;
    acc = 0.0;
    for (int n = 0; n < points; n++) begin
      ang = -2.0 * pi * k * n / points;
      if (imag) begin
        acc += case_re[c][n] * $sin(ang) + case_im[c][n] * $cos(ang);
      end else begin
        acc += case_re[c][n] * $cos(ang) - case_im[c][n] * $sin(ang);
      end
    end
    return acc;
  endfunction

  // tolerance of one LSB per point
  task automatic check_part(input string sig, input int bin, input int got, input real exp_v);
    real diff;
    diff = got - exp_v;
    if (diff < 0.0) begin
      diff = -diff;
    end
    if (diff > points) begin
      $display("ERR %0t %s[%0d] got %0d expected %0.2f", $time, sig, bin, got, exp_v);
      case_errs++;
    end
  endtask

  //==========================================================
  // stream tasks
  //==========================================================
  // handshakes are sampled at the falling edge
  task automatic load_block(input int c);
    int tries;
    for (int n = 0; n < points && !timed_out; n++) begin
      in_val = 1'b1;
      in_re  = sample_w'(case_re[c][n]);
      in_im  = sample_w'(case_im[c][n]);
      tries  = 0;
      @(negedge clk);
      while (!in_rdy && tries < timeout_cycles) begin
        @(negedge clk);
        tries++;
      end
      if (!in_rdy) begin
        $display("timeout: in_rdy stayed low at sample %0d of %s", n, case_name[c]);
        timed_out = 1'b1;
      end else begin
        @(posedge clk);
        #2;
      end
    end
    in_val = 1'b0;
  endtask

  // also covers the compute time before the first bin
  task automatic unload_block(input int c);
    int bin;
    int tries;
    bin   = 0;
    tries = 0;
    while (bin < points && !timed_out) begin
      out_rdy = case_stall[c] ? (($random(seed) & 3) != 0) : 1'b1;
      @(negedge clk);
      // no input is taken while computing or unloading
      if (in_rdy) begin
        $display("in_rdy high before bin %0d of %s was sent", bin, case_name[c]);
        case_errs++;
      end
      if (out_val && out_rdy) begin
        check_part("out_re", bin, out_re, dft_part(c, bin, 1'b0));
        check_part("out_im", bin, out_im, dft_part(c, bin, 1'b1));
        bin++;
        tries = 0;
      end else if (tries >= timeout_cycles) begin
        $display("timeout: bin %0d of %s never arrived", bin, case_name[c]);
        timed_out = 1'b1;
      end else begin
        tries++;
      end
      @(posedge clk);
      #2;
    end
    out_rdy = 1'b0;
    // no extra bin, and the engine is ready for the next block
    @(negedge clk);
    if (!timed_out && (out_val || !in_rdy)) begin
      $display("engine did not return to loading after %s", case_name[c]);
      case_errs++;
    end
    @(posedge clk);
    #2;
  endtask

  //==========================================================
  // main sequence
  //==========================================================
  initial begin
    int c;
    seed         = 32'h9452_000d;
    arst_n       = 1'b0;
    in_val       = 1'b0;
    in_re        = '0;
    in_im        = '0;
    out_rdy      = 1'b0;
    errors       = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;

    // no reset between blocks
    c = 0;
    while (c < num_cases && !timed_out) begin
      case_errs = 0;
      load_block(c);
      if (!timed_out) begin
        unload_block(c);
      end
      if (timed_out) begin
        case_errs++;
      end
      errors += case_errs;
      if (case_errs == 0) begin
        $display("case %0d %s: pass", c, case_name[c]);
      end else begin
        tests_failed++;
        $display("case %0d %s: fail with %0d errors", c, case_name[c], case_errs);
      end
      c++;
    end

    $display("cases run %0d of %0d, failed %0d, errors %0d", c, num_cases, tests_failed,
             errors);
    if (tests_failed == 0 && !timed_out && c == num_cases) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: fft_engine.f
+incdir+tests
src/fft_types_pkg.sv
src/fft_ctrl_pkg.sv
src/fft_complex_mult.sv
src/fft_butterfly.sv
src/fft_sample_ram.sv
src/fft_twiddle_rom.sv
src/fft_addr_counter.sv
src/fft_ctrl_fsm.sv
src/fft_engine.sv
tests/fft_engine_tb.sv

// File: Bender.yml
package:
  name: fft_engine

sources:
  - files:
      - src/fft_types_pkg.sv
      - src/fft_ctrl_pkg.sv
      - src/fft_complex_mult.sv
      - src/fft_butterfly.sv
      - src/fft_sample_ram.sv
      - src/fft_twiddle_rom.sv
      - src/fft_addr_counter.sv
      - src/fft_ctrl_fsm.sv
      - src/fft_engine.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/fft_engine_tb.sv
